// ==== action_table.sv ====
`timescale 1ns/1ps
`default_nettype none

module action_table #(
    parameter int NUM_ACTIONS = 10
) (
    input  wire logic                                                clk,
    input  wire logic                                                wr_en,
    input  wire logic [deparser_pkg::TABLE_ADDR_WIDTH-1:0]           wr_addr,
    input  wire logic [NUM_ACTIONS*deparser_pkg::ACTION_WIDTH-1:0]   wr_data,
    input  wire logic [deparser_pkg::TABLE_ADDR_WIDTH-1:0]           rd_addr,
    output logic      [NUM_ACTIONS*deparser_pkg::ACTION_WIDTH-1:0]   rd_data
);

    import deparser_pkg::*;

    localparam int ROW_WIDTH = NUM_ACTIONS * ACTION_WIDTH;

    logic [ROW_WIDTH-1:0] mem [0:TABLE_DEPTH-1];

    // read-before-write on a same-row collision
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
        rd_data <= mem[rd_addr];
    end

    // lookup address comes from the captured beat in the fsm
    a_rd_addr_known: assert property (@(posedge clk) !$isunknown(rd_addr))
        else $error("action table read address has unknown bits");

endmodule

`default_nettype wire

// ==== container_extract.sv ====
`timescale 1ns/1ps
`default_nettype none

module container_extract (
    input  wire logic                                         clk,
    input  wire logic                                         aresetn,
    input  wire logic                                         load,
    input  wire logic [deparser_pkg::PHV_WIDTH-1:0]           phv,
    input  wire logic [deparser_pkg::ACT_OFFSET_LSB-1:0]      act_sel,
    output logic      [deparser_pkg::MAX_VALUE_BYTES*8-1:0]   value,
    output logic      [deparser_pkg::ACT_TYPE_WIDTH-1:0]      size
);

    import deparser_pkg::*;

    localparam int VALUE_WIDTH = MAX_VALUE_BYTES * 8;

    logic [$clog2(NUM_CONTAINERS)-1:0] idx;
    logic [ACT_TYPE_WIDTH-1:0]         act_type;
    logic [VALUE_WIDTH-1:0]            raw;
    logic [VALUE_WIDTH-1:0]            swapped;
    int                                nbytes;

    assign idx      = act_sel[ACT_INDEX_LSB +: $clog2(NUM_CONTAINERS)];
    assign act_type = act_sel[ACT_TYPE_LSB +: ACT_TYPE_WIDTH];
    assign nbytes   = 2 * act_type;

    // container in phv order, low aligned
    always_comb begin
        raw = '0;
        case (act_type)
            ACT_TYPE_2B: raw[15:0] = phv[PHV_2B_BASE + idx*16 +: 16];
            ACT_TYPE_4B: raw[31:0] = phv[PHV_4B_BASE + idx*32 +: 32];
            ACT_TYPE_6B: raw       = phv[PHV_6B_BASE + idx*48 +: 48];
            default:     raw       = '0;
        endcase
    end

    // msb of the container goes to byte 0
    always_comb begin
        swapped = '0;
        for (int b = 0; b < MAX_VALUE_BYTES; b++) begin
            if (b < nbytes) begin
                swapped[b*8 +: 8] = raw[(nbytes - 1 - b)*8 +: 8];
            end
        end
    end

    always_ff @(posedge clk or negedge aresetn) begin
        if (!aresetn) begin
            size <= '0;
        end else if (load) begin
            size <= act_type;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            value <= swapped;
        end
    end

endmodule

`default_nettype wire

// ==== control_loader.sv ====
`timescale 1ns/1ps
`default_nettype none

module control_loader #(
    parameter int         DATA_WIDTH  = 512,
    parameter int         NUM_ACTIONS = 10,
    parameter logic [2:0] DEPARSER_ID = 3'd5
) (
    input  wire logic                                                clk,
    input  wire logic                                                aresetn,
    input  wire logic [DATA_WIDTH-1:0]                               c_tdata,
    input  wire logic                                                c_tvalid,
    input  wire logic                                                c_tlast,
    output logic                                                     wr_en,
    output logic      [deparser_pkg::TABLE_ADDR_WIDTH-1:0]           wr_addr,
    output logic      [NUM_ACTIONS*deparser_pkg::ACTION_WIDTH-1:0]   wr_data
);

    import deparser_pkg::*;

    localparam int  ROW_WIDTH = NUM_ACTIONS * ACTION_WIDTH;
    localparam logic S_IDLE   = 1'b0;
    localparam logic S_WRITE  = 1'b1;

    logic                  state;
    logic                  mid_pkt;
    logic                  hdr_ok;
    logic [DATA_WIDTH-1:0] swapped;

    // module id and flag must both match
    assign hdr_ok = c_tdata[CTRL_MOD_ID_LSB +: 3] == DEPARSER_ID &&
                    c_tdata[CTRL_FLAG_LSB +: 16] == CTRL_FLAG_VALUE;

    // full byte reversal of the entry beat
    always_comb begin
        for (int j = 0; j < DATA_WIDTH / 8; j++) begin
            swapped[j*8 +: 8] = c_tdata[DATA_WIDTH - 8 - j*8 +: 8];
        end
    end

    assign wr_en   = state == S_WRITE && c_tvalid;
    assign wr_data = swapped[DATA_WIDTH-1 -: ROW_WIDTH];

    always_ff @(posedge clk or negedge aresetn) begin
        if (!aresetn) begin
            state   <= S_IDLE;
            mid_pkt <= 1'b0;
            wr_addr <= '0;
        end else if (c_tvalid) begin
            mid_pkt <= !c_tlast;
            if (state == S_IDLE) begin
                // header only on the first beat of a packet
                if (!mid_pkt && hdr_ok && !c_tlast) begin
                    state   <= S_WRITE;
                    wr_addr <= c_tdata[CTRL_INDEX_LSB +: TABLE_ADDR_WIDTH];
                end
            end else begin
                wr_addr <= wr_addr + 1'b1;
                if (c_tlast) begin
                    state <= S_IDLE;
                end
            end
        end
    end

    // writes only on beats that follow an accepted header
    a_no_idle_write: assert property (@(posedge clk) disable iff (!aresetn)
        wr_en |-> mid_pkt)
        else $error("table write issued outside a control packet");

endmodule

`default_nettype wire

// ==== deparse_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

module deparse_fsm #(
    parameter int DATA_WIDTH  = 512,
    parameter int TUSER_WIDTH = 128,
    parameter int NUM_ACTIONS = 10
) (
    input  wire logic                                                 clk,
    input  wire logic                                                 aresetn,
    input  wire logic [DATA_WIDTH-1:0]                                pkt_fifo_tdata,
    input  wire logic [DATA_WIDTH/8-1:0]                              pkt_fifo_tkeep,
    input  wire logic [TUSER_WIDTH-1:0]                               pkt_fifo_tuser,
    input  wire logic                                                 pkt_fifo_tlast,
    input  wire logic                                                 pkt_fifo_empty,
    output logic                                                      pkt_fifo_rd_en,
    input  wire logic [deparser_pkg::PHV_WIDTH-1:0]                   phv_fifo_out,
    input  wire logic                                                 phv_fifo_empty,
    output logic                                                      phv_fifo_rd_en,
    output logic      [DATA_WIDTH-1:0]                                depar_out_tdata,
    output logic      [DATA_WIDTH/8-1:0]                              depar_out_tkeep,
    output logic      [TUSER_WIDTH-1:0]                               depar_out_tuser,
    output logic                                                      depar_out_tvalid,
    output logic                                                      depar_out_tlast,
    input  wire logic                                                 depar_out_tready,
    input  wire logic [NUM_ACTIONS*deparser_pkg::ACTION_WIDTH-1:0]    act_row,
    input  wire logic [NUM_ACTIONS*deparser_pkg::MAX_VALUE_BYTES*8-1:0] ext_value,
    input  wire logic [NUM_ACTIONS*deparser_pkg::ACT_TYPE_WIDTH-1:0]  ext_size,
    output logic      [deparser_pkg::TABLE_ADDR_WIDTH-1:0]            rd_addr,
    output logic      [deparser_pkg::PHV_WIDTH-1:0]                   phv_held,
    output logic                                                      extract_load
);

    import deparser_pkg::*;

    localparam int VALUE_WIDTH = MAX_VALUE_BYTES * 8;

    localparam logic [2:0] S_IDLE    = 3'd0;
    localparam logic [2:0] S_LOOKUP  = 3'd1;
    localparam logic [2:0] S_EXTRACT = 3'd2;
    localparam logic [2:0] S_REWRITE = 3'd3;
    localparam logic [2:0] S_HEAD    = 3'd4;
    localparam logic [2:0] S_PASS    = 3'd5;

    logic [2:0]              state;
    logic                    accept;
    logic [DATA_WIDTH-1:0]   head_tdata;
    logic [DATA_WIDTH/8-1:0] head_tkeep;
    logic [TUSER_WIDTH-1:0]  head_tuser;
    logic                    head_tlast;
    logic [DATA_WIDTH-1:0]   rewritten;

    assign accept         = state == S_IDLE && !pkt_fifo_empty && !phv_fifo_empty;
    assign extract_load   = state == S_EXTRACT;
    assign phv_fifo_rd_en = state == S_REWRITE;

    // head beat from registers, rest straight from the fifo
    always_comb begin
        if (state == S_PASS) begin
            depar_out_tdata  = pkt_fifo_tdata;
            depar_out_tkeep  = pkt_fifo_tkeep;
            depar_out_tuser  = pkt_fifo_tuser;
            depar_out_tlast  = pkt_fifo_tlast;
            depar_out_tvalid = !pkt_fifo_empty;
        end else begin
            depar_out_tdata  = head_tdata;
            depar_out_tkeep  = head_tkeep;
            depar_out_tuser  = head_tuser;
            depar_out_tlast  = head_tlast;
            depar_out_tvalid = state == S_HEAD;
        end
        pkt_fifo_rd_en = accept || (state == S_PASS && depar_out_tvalid && depar_out_tready);
    end

    // ascending order, so a higher index overwrites a lower one
    always_comb begin
        logic [ACTION_WIDTH-1:0] act;
        int                      nbytes;
        int                      pos;
        rewritten = head_tdata;
        for (int k = 0; k < NUM_ACTIONS; k++) begin
            act    = act_row[(NUM_ACTIONS - 1 - k)*ACTION_WIDTH +: ACTION_WIDTH];
            nbytes = 2 * ext_size[k*ACT_TYPE_WIDTH +: ACT_TYPE_WIDTH];
            for (int b = 0; b < MAX_VALUE_BYTES; b++) begin
                pos = act[ACT_OFFSET_LSB +: ACT_OFFSET_WIDTH] + b;
                if (act[ACT_VALID_BIT] && b < nbytes && pos < DATA_WIDTH / 8) begin
                    rewritten[pos*8 +: 8] = ext_value[k*VALUE_WIDTH + b*8 +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk or negedge aresetn) begin
        if (!aresetn) begin
            state   <= S_IDLE;
            rd_addr <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (accept) begin
                        rd_addr <= pkt_fifo_tdata[VLAN_LSB + 4 +: TABLE_ADDR_WIDTH];
                        state   <= S_LOOKUP;
                    end
                end
                S_LOOKUP:  state <= S_EXTRACT;
                S_EXTRACT: state <= S_REWRITE;
                S_REWRITE: state <= S_HEAD;
                S_HEAD: begin
                    if (depar_out_tready) begin
                        state <= head_tlast ? S_IDLE : S_PASS;
                    end
                end
                S_PASS: begin
                    if (depar_out_tvalid && depar_out_tready && pkt_fifo_tlast) begin
                        state <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            head_tdata <= pkt_fifo_tdata;
            head_tkeep <= pkt_fifo_tkeep;
            head_tuser <= pkt_fifo_tuser;
            head_tlast <= pkt_fifo_tlast;
            phv_held   <= phv_fifo_out;
        end else if (state == S_REWRITE) begin
            head_tdata <= rewritten;
        end
    end

    a_head_stable: assert property (@(posedge clk) disable iff (!aresetn)
        (state == S_HEAD && !depar_out_tready) |=>
            depar_out_tvalid && $stable(depar_out_tdata) && $stable(depar_out_tlast))
        else $error("head beat changed under back-pressure");

endmodule

`default_nettype wire

// ==== deparser_pkg.sv ====
`default_nettype none

package deparser_pkg;

    // header vector layout
    localparam int PHV_WIDTH      = 1124;
    localparam int PHV_2B_BASE    = 356;
    localparam int PHV_4B_BASE    = 484;
    localparam int PHV_6B_BASE    = 740;
    localparam int NUM_CONTAINERS = 8;

    // action word fields
    localparam int ACTION_WIDTH     = 16;
    localparam int ACT_VALID_BIT    = 0;
    localparam int ACT_INDEX_LSB    = 1;
    localparam int ACT_TYPE_LSB     = 4;
    localparam int ACT_TYPE_WIDTH   = 2;
    localparam int ACT_OFFSET_LSB   = 6;
    localparam int ACT_OFFSET_WIDTH = 7;

    localparam logic [1:0] ACT_TYPE_2B = 2'd1;
    localparam logic [1:0] ACT_TYPE_4B = 2'd2;
    localparam logic [1:0] ACT_TYPE_6B = 2'd3;

    localparam int MAX_VALUE_BYTES = 6;

    // table addressed by vlan bits 7:4
    localparam int VLAN_LSB         = 116;
    localparam int TABLE_DEPTH      = 16;
    localparam int TABLE_ADDR_WIDTH = 4;

    // control header fields
    localparam int CTRL_MOD_ID_LSB = 368;
    localparam int CTRL_FLAG_LSB   = 320;
    localparam int CTRL_INDEX_LSB  = 384;

    localparam logic [15:0] CTRL_FLAG_VALUE = 16'hf2f1;

endpackage

`default_nettype wire

// ==== deparser_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module deparser_top #(
    parameter int         DATA_WIDTH  = 512,
    parameter int         TUSER_WIDTH = 128,
    parameter int         NUM_ACTIONS = 10,
    parameter logic [2:0] DEPARSER_ID = 3'd5
) (
    input  wire logic                                clk,
    input  wire logic                                aresetn,
    input  wire logic [DATA_WIDTH-1:0]               pkt_fifo_tdata,
    input  wire logic [DATA_WIDTH/8-1:0]             pkt_fifo_tkeep,
    input  wire logic [TUSER_WIDTH-1:0]              pkt_fifo_tuser,
    input  wire logic                                pkt_fifo_tlast,
    input  wire logic                                pkt_fifo_empty,
    output logic                                     pkt_fifo_rd_en,
    input  wire logic [deparser_pkg::PHV_WIDTH-1:0]  phv_fifo_out,
    input  wire logic                                phv_fifo_empty,
    output logic                                     phv_fifo_rd_en,
    output logic      [DATA_WIDTH-1:0]               depar_out_tdata,
    output logic      [DATA_WIDTH/8-1:0]             depar_out_tkeep,
    output logic      [TUSER_WIDTH-1:0]              depar_out_tuser,
    output logic                                     depar_out_tvalid,
    output logic                                     depar_out_tlast,
    input  wire logic                                depar_out_tready,
    input  wire logic [DATA_WIDTH-1:0]               c_s_axis_tdata,
    input  wire logic                                c_s_axis_tvalid,
    input  wire logic                                c_s_axis_tlast
);

    import deparser_pkg::*;

    localparam int ROW_WIDTH   = NUM_ACTIONS * ACTION_WIDTH;
    localparam int VALUE_WIDTH = MAX_VALUE_BYTES * 8;

    logic                                   tbl_wr_en;
    logic [TABLE_ADDR_WIDTH-1:0]            tbl_wr_addr;
    logic [ROW_WIDTH-1:0]                   tbl_wr_data;
    logic [TABLE_ADDR_WIDTH-1:0]            tbl_rd_addr;
    logic [ROW_WIDTH-1:0]                   act_row;
    logic [PHV_WIDTH-1:0]                   phv_held;
    logic                                   extract_load;
    logic [NUM_ACTIONS*VALUE_WIDTH-1:0]     ext_value;
    logic [NUM_ACTIONS*ACT_TYPE_WIDTH-1:0]  ext_size;

    control_loader #(
        .DATA_WIDTH  (DATA_WIDTH),
        .NUM_ACTIONS (NUM_ACTIONS),
        .DEPARSER_ID (DEPARSER_ID)
    ) u_loader (
        .clk      (clk),
        .aresetn  (aresetn),
        .c_tdata  (c_s_axis_tdata),
        .c_tvalid (c_s_axis_tvalid),
        .c_tlast  (c_s_axis_tlast),
        .wr_en    (tbl_wr_en),
        .wr_addr  (tbl_wr_addr),
        .wr_data  (tbl_wr_data)
    );

    action_table #(
        .NUM_ACTIONS (NUM_ACTIONS)
    ) u_table (
        .clk     (clk),
        .wr_en   (tbl_wr_en),
        .wr_addr (tbl_wr_addr),
        .wr_data (tbl_wr_data),
        .rd_addr (tbl_rd_addr),
        .rd_data (act_row)
    );

    // action 0 sits in the top word of the row
    for (genvar k = 0; k < NUM_ACTIONS; k++) begin : g_extract
        container_extract u_extract (
            .clk     (clk),
            .aresetn (aresetn),
            .load    (extract_load),
            .phv     (phv_held),
            .act_sel (act_row[(NUM_ACTIONS - 1 - k)*ACTION_WIDTH +: ACT_OFFSET_LSB]),
            .value   (ext_value[k*VALUE_WIDTH +: VALUE_WIDTH]),
            .size    (ext_size[k*ACT_TYPE_WIDTH +: ACT_TYPE_WIDTH])
        );
    end

    deparse_fsm #(
        .DATA_WIDTH  (DATA_WIDTH),
        .TUSER_WIDTH (TUSER_WIDTH),
        .NUM_ACTIONS (NUM_ACTIONS)
    ) u_fsm (
        .clk              (clk),
        .aresetn          (aresetn),
        .pkt_fifo_tdata   (pkt_fifo_tdata),
        .pkt_fifo_tkeep   (pkt_fifo_tkeep),
        .pkt_fifo_tuser   (pkt_fifo_tuser),
        .pkt_fifo_tlast   (pkt_fifo_tlast),
        .pkt_fifo_empty   (pkt_fifo_empty),
        .pkt_fifo_rd_en   (pkt_fifo_rd_en),
        .phv_fifo_out     (phv_fifo_out),
        .phv_fifo_empty   (phv_fifo_empty),
        .phv_fifo_rd_en   (phv_fifo_rd_en),
        .depar_out_tdata  (depar_out_tdata),
        .depar_out_tkeep  (depar_out_tkeep),
        .depar_out_tuser  (depar_out_tuser),
        .depar_out_tvalid (depar_out_tvalid),
        .depar_out_tlast  (depar_out_tlast),
        .depar_out_tready (depar_out_tready),
        .act_row          (act_row),
        .ext_value        (ext_value),
        .ext_size         (ext_size),
        .rd_addr          (tbl_rd_addr),
        .phv_held         (phv_held),
        .extract_load     (extract_load)
    );

endmodule

`default_nettype wire

// ==== project.f ====
deparser_pkg.sv
action_table.sv
control_loader.sv
container_extract.sv
deparse_fsm.sv
deparser_top.sv
tb_deparser.sv

// ==== tb_deparser.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_deparser;

    import deparser_pkg::*;

    localparam int          DATA_W  = 512;
    localparam int          USER_W  = 128;
    localparam int          BEAT_W  = 1 + USER_W + DATA_W / 8 + DATA_W;
    localparam int          NUM_ACT = 10;
    localparam logic [2:0]  OWN_ID  = 3'd5;
    localparam int          MARGIN  = 200;

    logic                  clk;
    logic                  aresetn;
    logic [DATA_W-1:0]     pkt_fifo_tdata;
    logic [DATA_W/8-1:0]   pkt_fifo_tkeep;
    logic [USER_W-1:0]     pkt_fifo_tuser;
    logic                  pkt_fifo_tlast;
    logic                  pkt_fifo_empty;
    logic                  pkt_fifo_rd_en;
    logic [PHV_WIDTH-1:0]  phv_fifo_out;
    logic                  phv_fifo_empty;
    logic                  phv_fifo_rd_en;
    logic [DATA_W-1:0]     depar_out_tdata;
    logic [DATA_W/8-1:0]   depar_out_tkeep;
    logic [USER_W-1:0]     depar_out_tuser;
    logic                  depar_out_tvalid;
    logic                  depar_out_tlast;
    logic                  depar_out_tready;
    logic [DATA_W-1:0]     c_s_axis_tdata;
    logic                  c_s_axis_tvalid;
    logic                  c_s_axis_tlast;

    // fifo and expectation models
    // each beat packs {tlast, tuser, tkeep, tdata}
    logic [BEAT_W-1:0]     pk_q [$];
    logic [PHV_WIDTH-1:0]  phv_q [$];
    logic [BEAT_W-1:0]     exp_q [$];
    logic [BEAT_W-1:0]     exp_beat;
    logic                  exp_any;
    logic [BEAT_W-1:0]     out_beat;
    logic                  pkt_pop;
    logic                  phv_pop;
    logic                  beat_done;
    logic                  rand_ready;

    logic [15:0]           act_model [0:TABLE_DEPTH-1][0:NUM_ACT-1];
    logic [15:0]           new_act [0:3][0:NUM_ACT-1];
    logic [31:0]           lfsr_data;
    logic [31:0]           lfsr_rdy;
    string                 test_name;
    int                    errors;
    int                    errors_at_start;
    int                    tests_run;
    int                    tests_failed;
    int                    budget;
    int                    cycles;

    deparser_top dut (
        .clk              (clk),
        .aresetn          (aresetn),
        .pkt_fifo_tdata   (pkt_fifo_tdata),
        .pkt_fifo_tkeep   (pkt_fifo_tkeep),
        .pkt_fifo_tuser   (pkt_fifo_tuser),
        .pkt_fifo_tlast   (pkt_fifo_tlast),
        .pkt_fifo_empty   (pkt_fifo_empty),
        .pkt_fifo_rd_en   (pkt_fifo_rd_en),
        .phv_fifo_out     (phv_fifo_out),
        .phv_fifo_empty   (phv_fifo_empty),
        .phv_fifo_rd_en   (phv_fifo_rd_en),
        .depar_out_tdata  (depar_out_tdata),
        .depar_out_tkeep  (depar_out_tkeep),
        .depar_out_tuser  (depar_out_tuser),
        .depar_out_tvalid (depar_out_tvalid),
        .depar_out_tlast  (depar_out_tlast),
        .depar_out_tready (depar_out_tready),
        .c_s_axis_tdata   (c_s_axis_tdata),
        .c_s_axis_tvalid  (c_s_axis_tvalid),
        .c_s_axis_tlast   (c_s_axis_tlast)
    );

    assign out_beat = {depar_out_tlast, depar_out_tuser, depar_out_tkeep, depar_out_tdata};

    always #50 clk = ~clk;

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? (s >> 1) ^ 32'h8020_0003 : s >> 1;
    endfunction

    // one lfsr step per bit
    function automatic logic [PHV_WIDTH-1:0] take_bits(input int n);
        logic [PHV_WIDTH-1:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v[i]      = lfsr_data[0];
            lfsr_data = lfsr_step(lfsr_data);
        end
        return v;
    endfunction

    // random enable, index, type and offset
    function automatic logic [15:0] rand_action();
        logic [PHV_WIDTH-1:0] v;
        v = take_bits(13);
        return v[15:0];
    endfunction

    function automatic logic [15:0] act_word(input logic v, input logic [2:0] idx,
                                             input logic [1:0] t, input logic [6:0] off);
        return {3'b000, off, t, idx, v};
    endfunction

    // expected first beat with each container msb first at its offset
    function automatic logic [DATA_W-1:0] rewrite_head(input logic [DATA_W-1:0] d,
                                                       input logic [PHV_WIDTH-1:0] phv);
        logic [DATA_W-1:0] o;
        logic [15:0]       a;
        logic [47:0]       c;
        int                n;
        int                base;
        int                off;
        o = d;
        for (int k = 0; k < NUM_ACT; k++) begin
            a    = act_model[d[123:120]][k];
            n    = 2 * a[5:4];
            base = a[5:4] == 2'd1 ? PHV_2B_BASE : a[5:4] == 2'd2 ? PHV_4B_BASE : PHV_6B_BASE;
            c    = phv[base + a[3:1] * n * 8 +: 48];
            for (int b = 0; b < n; b++) begin
                off = a[12:6] + b;
                if (a[0] && off < DATA_W / 8) begin
                    o[off*8 +: 8] = c[(n - 1 - b)*8 +: 8];
                end
            end
        end
        return o;
    endfunction

    task automatic clear_rows();
        for (int r = 0; r < 4; r++) begin
            for (int k = 0; k < NUM_ACT; k++) begin
                new_act[r][k] = '0;
            end
        end
    endtask

    // header beat followed by one entry beat per row
    task automatic load_rows(input logic [2:0] mod_id, input logic [15:0] flag,
                             input logic [3:0] start, input int count);
        logic [DATA_W-1:0]    beat;
        logic [PHV_WIDTH-1:0] r;
        logic [3:0]           addr;
        r    = take_bits(DATA_W);
        beat = r[DATA_W-1:0];
        beat[CTRL_MOD_ID_LSB +: 3] = mod_id;
        beat[CTRL_FLAG_LSB +: 16]  = flag;
        beat[CTRL_INDEX_LSB +: 4]  = start;
        @(negedge clk);
        c_s_axis_tdata  = beat;
        c_s_axis_tvalid = 1'b1;
        c_s_axis_tlast  = count == 0;
        for (int i = 0; i < count; i++) begin
            r    = take_bits(DATA_W);
            beat = r[DATA_W-1:0];
            for (int k = 0; k < NUM_ACT; k++) begin
                beat[16*k +: 8]     = new_act[i][k][15:8];
                beat[16*k + 8 +: 8] = new_act[i][k][7:0];
            end
            @(negedge clk);
            c_s_axis_tdata = beat;
            c_s_axis_tlast = i == count - 1;
        end
        @(negedge clk);
        c_s_axis_tvalid = 1'b0;
        c_s_axis_tlast  = 1'b0;
        addr = start;
        if (mod_id == OWN_ID && flag == CTRL_FLAG_VALUE && count > 0) begin
            for (int i = 0; i < count; i++) begin
                for (int k = 0; k < NUM_ACT; k++) begin
                    act_model[addr][k] = new_act[i][k];
                end
                addr = addr + 4'd1;
            end
        end
        budget += count + 2;
    endtask

    task automatic send_pkt(input logic [3:0] vlan, input int nbeats);
        logic [PHV_WIDTH-1:0] phv;
        logic [PHV_WIDTH-1:0] r;
        logic [DATA_W-1:0]    d;
        logic [DATA_W/8-1:0]  keep;
        logic [USER_W-1:0]    user;
        @(posedge clk);
        phv = take_bits(PHV_WIDTH);
        phv_q.push_back(phv);
        for (int i = 0; i < nbeats; i++) begin
            r    = take_bits(DATA_W);
            d    = r[DATA_W-1:0];
            r    = take_bits(DATA_W / 8);
            keep = r[DATA_W/8-1:0];
            r    = take_bits(USER_W);
            user = r[USER_W-1:0];
            if (i == 0) begin
                d[123:120] = vlan;
            end
            pk_q.push_back({i == nbeats - 1, user, keep, d});
            exp_q.push_back({i == nbeats - 1, user, keep, i == 0 ? rewrite_head(d, phv) : d});
        end
        budget += 6 + nbeats;
    endtask

    task automatic start_test(input string name);
        test_name       = name;
        errors_at_start = errors;
    endtask

    task automatic report_test();
        while (exp_q.size() != 0 || pk_q.size() != 0 || phv_q.size() != 0) begin
            @(posedge clk);
        end
        repeat (2) @(posedge clk);
        tests_run++;
        if (errors != errors_at_start) begin
            tests_failed++;
        end
        $display("test %-14s %s (%0d errors)", test_name,
                 errors == errors_at_start ? "ok" : "FAILED", errors - errors_at_start);
    endtask

    always @(posedge clk) begin
        pkt_pop   <= pkt_fifo_rd_en;
        phv_pop   <= phv_fifo_rd_en;
        beat_done <= depar_out_tvalid && depar_out_tready;
    end

    // pops take effect here before the fifo heads are driven again
    always @(negedge clk) begin
        if (pkt_pop) void'(pk_q.pop_front());
        if (phv_pop) void'(phv_q.pop_front());
        if (beat_done && exp_q.size() != 0) void'(exp_q.pop_front());
        pkt_fifo_empty = pk_q.size() == 0;
        phv_fifo_empty = phv_q.size() == 0;
        if (!pkt_fifo_empty) begin
            {pkt_fifo_tlast, pkt_fifo_tuser, pkt_fifo_tkeep, pkt_fifo_tdata} = pk_q[0];
        end
        if (!phv_fifo_empty) begin
            phv_fifo_out = phv_q[0];
        end
        exp_any = exp_q.size() != 0;
        if (exp_any) begin
            exp_beat = exp_q[0];
        end
        depar_out_tready = rand_ready ? lfsr_rdy[0] : 1'b1;
        if (rand_ready) begin
            lfsr_rdy = lfsr_step(lfsr_rdy);
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > 2 * budget + MARGIN) begin
            $display("timeout after %0d cycles in %s, output beats missing", cycles, test_name);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    a_beat_expected: assert property (@(posedge clk) disable iff (!aresetn)
        (depar_out_tvalid && depar_out_tready) |-> exp_any)
        else begin
            $display("unexpected output beat in %s", test_name);
            errors++;
        end

    a_beat_value: assert property (@(posedge clk) disable iff (!aresetn)
        (depar_out_tvalid && depar_out_tready && exp_any) |-> out_beat == exp_beat)
        else begin
            $display("Mismatch in %s: expected %h actual %h", test_name,
                     $sampled(exp_beat), $sampled(out_beat));
            errors++;
        end

    // head beat valid four cycles after the accept cycle
    a_head_latency: assert property (@(posedge clk) disable iff (!aresetn)
        (pkt_fifo_rd_en && !depar_out_tvalid) |=> !depar_out_tvalid [*2] ##1
            (phv_fifo_rd_en && !depar_out_tvalid) ##1 depar_out_tvalid)
        else begin
            $display("head beat did not follow its accept by four cycles in %s", test_name);
            errors++;
        end

    initial begin
        clk             = 1'b0;
        aresetn         = 1'b0;
        pkt_fifo_tdata  = '0;
        pkt_fifo_tkeep  = '0;
        pkt_fifo_tuser  = '0;
        pkt_fifo_tlast  = 1'b0;
        pkt_fifo_empty  = 1'b1;
        phv_fifo_out    = '0;
        phv_fifo_empty  = 1'b1;
        depar_out_tready = 1'b1;
        c_s_axis_tdata  = '0;
        c_s_axis_tvalid = 1'b0;
        c_s_axis_tlast  = 1'b0;
        pkt_pop         = 1'b0;
        phv_pop         = 1'b0;
        beat_done       = 1'b0;
        rand_ready      = 1'b0;
        exp_any         = 1'b0;
        exp_beat        = '0;
        lfsr_data       = 32'd48;
        lfsr_rdy        = 32'd48;
        test_name       = "reset";
        errors          = 0;
        tests_run       = 0;
        tests_failed    = 0;
        budget          = 16;
        cycles          = 0;
        repeat (16) @(negedge clk);
        aresetn = 1'b1;

        start_test("load_rewrite");
        clear_rows();
        new_act[0][0] = act_word(1'b1, 3'd2, 2'd1, 7'd10);
        new_act[0][1] = act_word(1'b1, 3'd5, 2'd2, 7'd20);
        new_act[0][2] = act_word(1'b1, 3'd7, 2'd3, 7'd40);
        load_rows(OWN_ID, CTRL_FLAG_VALUE, 4'd3, 1);
        send_pkt(4'd3, 1);
        report_test();

        start_test("disabled");
        clear_rows();
        new_act[0][0] = act_word(1'b0, 3'd1, 2'd2, 7'd8);
        new_act[0][1] = act_word(1'b1, 3'd3, 2'd0, 7'd16);
        new_act[0][2] = act_word(1'b0, 3'd7, 2'd3, 7'd0);
        load_rows(OWN_ID, CTRL_FLAG_VALUE, 4'd4, 1);
        send_pkt(4'd4, 1);
        report_test();

        // wrong id, wrong flag and a header with tlast leave row 3 alone
        start_test("filter");
        clear_rows();
        new_act[0][4] = act_word(1'b1, 3'd0, 2'd3, 7'd2);
        load_rows(3'd6, CTRL_FLAG_VALUE, 4'd3, 1);
        load_rows(OWN_ID, 16'hf2f0, 4'd3, 1);
        load_rows(OWN_ID, CTRL_FLAG_VALUE, 4'd3, 0);
        send_pkt(4'd3, 2);
        report_test();

        start_test("multi_row");
        for (int r = 0; r < 3; r++) begin
            for (int k = 0; k < NUM_ACT; k++) begin
                new_act[r][k] = rand_action();
            end
        end
        load_rows(OWN_ID, CTRL_FLAG_VALUE, 4'd8, 3);
        send_pkt(4'd8, 3);
        send_pkt(4'd9, 1);
        send_pkt(4'd10, 4);
        report_test();

        start_test("overlap");
        clear_rows();
        new_act[0][0] = act_word(1'b1, 3'd0, 2'd1, 7'd31);
        new_act[0][1] = act_word(1'b1, 3'd4, 2'd3, 7'd30);
        new_act[0][6] = act_word(1'b1, 3'd2, 2'd2, 7'd32);
        new_act[0][9] = act_word(1'b1, 3'd1, 2'd3, 7'd62);
        load_rows(OWN_ID, CTRL_FLAG_VALUE, 4'd12, 1);
        send_pkt(4'd12, 1);
        report_test();

        start_test("backpressure");
        rand_ready = 1'b1;
        send_pkt(4'd8, 3);
        send_pkt(4'd12, 2);
        send_pkt(4'd9, 1);
        send_pkt(4'd10, 5);
        report_test();
        rand_ready = 1'b0;

        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (tests_failed == 0 && errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire
